/* src.f */
+incdir+include
source/apu_pkg.sv
source/apu_dispatcher.sv
source/apu_unit.sv
source/apu_writeback_rf.sv
source/apu_subsystem_top.sv
verification/apu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module apu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vapu_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

/* verification/apu_tb.sv */
//////////////////////////////////////////////////////////////////////
// Directed testbench for the accelerator dispatch subsystem
// Inputs change 1 ns after the rising edge, outputs sampled at negedge
// Expected register contents kept in a testbench model array
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "apu_settings.svh"

module apu_tb
  import apu_pkg::*;
;

  localparam int W       = `APU_DATA_W;
  localparam int TIMEOUT = 100;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      req_valid_i;
  apu_req_t                  req_i;
  apu_reg_t [`APU_NARGS-1:0] rs_addr_i;
  logic [`APU_NARGS-1:0]     rs_valid_i;
  apu_reg_t                  wr_addr_i;
  logic                      wr_valid_i;
  apu_reg_t                  rd_addr_i;
  logic                      stall_o, active_o, read_dep_o, write_dep_o;
  apu_data_t                 rd_data_o;

  apu_data_t   model_rf [32];
  logic [31:0] lfsr_q;
  logic        s1, s2;
  int          tests, checks, errors, err_mark;

  apu_subsystem_top u_apu_subsystem_top (.*);

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w      = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return w;
  endfunction

  // Reference arithmetic straight from the operation definitions
  function automatic apu_data_t model_op(apu_op_e op, apu_data_t a, apu_data_t b);
    logic [2*W-1:0] p;
    p = (2*W)'(a) * (2*W)'(b);
    case (op)
      APU_ADD:   return a + b;
      APU_SUB:   return a - b;
      APU_MUL:   return p[W-1:0];
      APU_MULHU: return p[2*W-1:W];
      APU_DIVU:  return (b == '0) ? '1 : a / b;
      default:   return (b == '0) ? a : a % b;
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Something failed");
    $finish;
  endtask

  task automatic check_val(input string name, input apu_data_t exp, input apu_data_t act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%s finished with %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // Hold the request until it is taken, report any stall seen
  task automatic issue_op(input apu_op_e op, input apu_data_t a, input apu_data_t b,
                          input apu_reg_t rd, output logic stalled);
    int n;
    n           = 0;
    stalled     = 1'b0;
    req_valid_i = 1'b1;
    req_i       = '{op: op, op_a: a, op_b: b, rd: rd};
    @(negedge clk_i);
    while (stall_o && n < TIMEOUT) begin
      stalled = 1'b1;
      n++;
      @(negedge clk_i);
    end
    if (stall_o) begin
      abort_run("request still stalled after the timeout");
    end else begin
      @(posedge clk_i);
      #1;
      req_valid_i = 1'b0;
    end
  endtask

  task automatic run_op(input apu_op_e op, input apu_data_t a, input apu_data_t b,
                        input apu_reg_t rd, output logic stalled);
    issue_op(op, a, b, rd, stalled);
    if (rd != '0) model_rf[rd] = model_op(op, a, b);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (active_o && n < TIMEOUT) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (active_o) abort_run("active_o did not fall before the timeout");
  endtask

  // One cycle per register read, sampled at the falling edge
  task automatic check_reg(input apu_reg_t r);
    rd_addr_i = r;
    @(negedge clk_i);
    check_val($sformatf("rd_data_o[x%0d]", r), model_rf[r], rd_data_o);
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_deps(input logic exp_rd, input logic exp_wr);
    @(negedge clk_i);
    check_val("read_dep_o", apu_data_t'(exp_rd), apu_data_t'(read_dep_o));
    check_val("write_dep_o", apu_data_t'(exp_wr), apu_data_t'(write_dep_o));
    @(posedge clk_i);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic reset_state_checks();
    @(negedge clk_i);
    check_val("stall_o", '0, apu_data_t'(stall_o));
    check_val("active_o", '0, apu_data_t'(active_o));
    check_val("read_dep_o", '0, apu_data_t'(read_dep_o));
    check_val("write_dep_o", '0, apu_data_t'(write_dep_o));
    @(posedge clk_i);
    #1;
    check_reg(5'd1);
    check_reg(5'd17);
    check_reg(5'd31);
    finish_test("reset state");
  endtask

  task automatic same_cycle_ops();
    for (int i = 1; i <= 6; i++) begin
      run_op((rand_bits(1) != '0) ? APU_SUB : APU_ADD, rand_bits(32), rand_bits(32),
             apu_reg_t'(i), s1);
    end
    // Register 0 stays zero
    run_op(APU_ADD, rand_bits(32), rand_bits(32), 5'd0, s1);
    for (int i = 0; i <= 6; i++) begin
      check_reg(apu_reg_t'(i));
    end
    finish_test("same cycle ops");
  endtask

  task automatic multiply_pipeline();
    // Class difference of 1 holds the MUL back
    run_op(APU_MULHU, rand_bits(32), rand_bits(32), 5'd11, s1);
    run_op(APU_MUL, rand_bits(32), rand_bits(32), 5'd12, s2);
    check_val("stall_o seen for MUL after MULHU", 32'd1, apu_data_t'(s2));
    run_op(APU_MUL, rand_bits(32), rand_bits(32), 5'd13, s1);
    run_op(APU_MULHU, rand_bits(32), rand_bits(32), 5'd14, s2);
    check_val("stall_o seen for MULHU after MUL", 32'd0, apu_data_t'(s2));
    wait_idle();
    for (int i = 11; i <= 14; i++) begin
      check_reg(apu_reg_t'(i));
    end
    finish_test("multiply pipeline");
  endtask

  task automatic stall_behavior();
    // Same cycle op behind an active MUL
    run_op(APU_MUL, rand_bits(32), rand_bits(32), 5'd6, s1);
    run_op(APU_ADD, rand_bits(32), rand_bits(32), 5'd7, s2);
    check_val("stall_o seen for ADD behind MUL", 32'd1, apu_data_t'(s2));
    wait_idle();
    check_reg(5'd6);
    check_reg(5'd7);
    // Two MULHU fill both slots, the third waits
    run_op(APU_MULHU, rand_bits(32), rand_bits(32), 5'd8, s1);
    run_op(APU_MULHU, rand_bits(32), rand_bits(32), 5'd9, s1);
    run_op(APU_MULHU, rand_bits(32), rand_bits(32), 5'd10, s2);
    check_val("stall_o seen with both slots full", 32'd1, apu_data_t'(s2));
    wait_idle();
    check_reg(5'd8);
    check_reg(5'd9);
    check_reg(5'd10);
    // Later write replaces the MUL result
    run_op(APU_SUB, rand_bits(32), rand_bits(32), 5'd6, s1);
    wait_idle();
    check_reg(5'd6);
    finish_test("type and full stalls");
  endtask

  task automatic dependency_flags();
    run_op(APU_DIVU, rand_bits(32), rand_bits(12), 5'd5, s1);
    rs_addr_i[0] = 5'd5;
    rs_valid_i   = 2'b01;
    check_deps(1'b1, 1'b0);
    wr_addr_i  = 5'd5;
    wr_valid_i = 1'b1;
    check_deps(1'b1, 1'b1);
    // Register 0 and invalid sources never match
    rs_addr_i[0] = 5'd0;
    wr_addr_i    = 5'd0;
    check_deps(1'b0, 1'b0);
    rs_addr_i[0] = 5'd5;
    rs_valid_i   = 2'b00;
    wr_valid_i   = 1'b0;
    check_deps(1'b0, 1'b0);
    rs_valid_i = 2'b01;
    wr_addr_i  = 5'd5;
    wr_valid_i = 1'b1;
    wait_idle();
    check_deps(1'b0, 1'b0);
    rs_valid_i = '0;
    wr_valid_i = 1'b0;
    check_reg(5'd5);
    finish_test("dependencies");
  endtask

  task automatic division_results();
    for (int i = 0; i < 4; i++) begin
      run_op((rand_bits(1) != '0) ? APU_REMU : APU_DIVU, rand_bits(32), rand_bits(12),
             apu_reg_t'(16 + i), s1);
      wait_idle();
    end
    // Divide by zero
    run_op(APU_DIVU, rand_bits(32), '0, 5'd20, s1);
    wait_idle();
    run_op(APU_REMU, rand_bits(32), '0, 5'd21, s1);
    wait_idle();
    for (int i = 16; i <= 21; i++) begin
      check_reg(apu_reg_t'(i));
    end
    finish_test("division");
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rs_addr_i   = '0;
    rs_valid_i  = '0;
    wr_addr_i   = '0;
    wr_valid_i  = 1'b0;
    rd_addr_i   = '0;
    lfsr_q      = 32'hffa7;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    err_mark    = 0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    reset_state_checks();
    same_cycle_ops();
    multiply_pipeline();
    stall_behavior();
    dependency_flags();
    division_results();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* source/apu_subsystem_top.sv */
//////////////////////////////////////////////////////////////////////
// Accelerator dispatch subsystem: dispatcher, unit, register file
// Request is taken in the first cycle with req_valid_i and no stall
// Result readable class latency plus one edge after it is taken
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "apu_settings.svh"

module apu_subsystem_top
  import apu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_valid_i,
  input  apu_req_t                  req_i,
  input  apu_reg_t [`APU_NARGS-1:0] rs_addr_i,
  input  logic [`APU_NARGS-1:0]     rs_valid_i,
  input  apu_reg_t                  wr_addr_i,
  input  logic                      wr_valid_i,
  input  apu_reg_t                  rd_addr_i,
  output logic                      stall_o,
  output logic                      active_o,
  output logic                      read_dep_o,
  output logic                      write_dep_o,
  output apu_data_t                 rd_data_o
);

  // Dispatcher to unit
  logic       issue_req, issue_gnt;
  apu_issue_t issue;
  // Unit to dispatcher
  logic       result_valid;
  apu_data_t  result;
  // Dispatcher to register file
  logic       wb_valid;
  apu_rsp_t   wb;

  apu_dispatcher u_dispatcher (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .rs_addr_i      (rs_addr_i),
    .rs_valid_i     (rs_valid_i),
    .wr_addr_i      (wr_addr_i),
    .wr_valid_i     (wr_valid_i),
    .issue_req_o    (issue_req),
    .issue_o        (issue),
    .issue_gnt_i    (issue_gnt),
    .result_valid_i (result_valid),
    .result_i       (result),
    .wb_valid_o     (wb_valid),
    .wb_o           (wb),
    .stall_o        (stall_o),
    .active_o       (active_o),
    .read_dep_o     (read_dep_o),
    .write_dep_o    (write_dep_o)
  );

  apu_unit u_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_req_i    (issue_req),
    .issue_i        (issue),
    .issue_gnt_o    (issue_gnt),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  apu_writeback_rf u_writeback_rf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_valid_i (wb_valid),
    .wb_i       (wb),
    .rd_addr_i  (rd_addr_i),
    .rd_data_o  (rd_data_o)
  );

endmodule

/* source/apu_writeback_rf.sv */
//////////////////////////////////////////////////////////////////////
// Writeback register file, one write port and one read port
// Write lands at the next edge, read is combinational
// Register 0 reads as zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "apu_settings.svh"

module apu_writeback_rf
  import apu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wb_valid_i,
  input  apu_rsp_t  wb_i,
  input  apu_reg_t  rd_addr_i,
  output apu_data_t rd_data_o
);

  localparam int unsigned NREGS = 2 ** `APU_REG_AW;

  apu_data_t rf_q [NREGS];

  // All registers clear on reset
  // Register 0 ignores writes and keeps its reset value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NREGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (wb_valid_i && (wb_i.rd != '0)) begin
      rf_q[wb_i.rd] <= wb_i.result;
    end
  end

  assign rd_data_o = rf_q[rd_addr_i];

  // Dispatcher filters writes to register 0
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_valid_i |-> (wb_i.rd != '0))
    else $error("apu_writeback_rf: write to register 0");

endmodule

/* source/apu_unit.sv */
//////////////////////////////////////////////////////////////////////
// Arithmetic unit: add/sub same cycle, MUL one stage, MULHU two stages
// Unsigned divider, two quotient bits per cycle, no grant while busy
// Results are one-cycle strobes without back-pressure
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "apu_settings.svh"

module apu_unit
  import apu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       issue_req_i,
  input  apu_issue_t issue_i,
  output logic       issue_gnt_o,
  output logic       result_valid_o,
  output apu_data_t  result_o
);

  localparam int unsigned W  = `APU_DATA_W;
  localparam int unsigned CW = $clog2(`APU_DIV_CYCLES + 1);

  typedef enum logic {
    DIV_IDLE,
    DIV_BUSY
  } div_state_e;

  div_state_e        state_q;
  logic [CW-1:0]     cnt_q;
  logic              fire, same_v, div_start, div_done;
  logic              mul_v1_q, mulhu_v1_q, mulhu_v2_q;
  apu_lat_t          lat;
  apu_data_t         sum;
  logic [2*W-1:0]    prod, prod_q;
  apu_data_t         hi_q;
  logic [W:0]        rem_q, rem_in, rem_n;
  apu_data_t         quo_q, quo_in, quo_n, dvs_q, dvs_in;
  logic              is_rem_q;

  assign issue_gnt_o = (state_q == DIV_IDLE);
  assign fire        = issue_req_i & issue_gnt_o;
  assign lat         = apu_latency(issue_i.op);

  // Same cycle path
  assign sum    = (issue_i.op == APU_SUB) ? issue_i.op_a - issue_i.op_b
                                          : issue_i.op_a + issue_i.op_b;
  assign same_v = fire & (lat == 2'd0);

  ////////////////////////////////////////////////////////////////////
  // Multiply pipeline
  ////////////////////////////////////////////////////////////////////

  assign prod = {{W{1'b0}}, issue_i.op_a} * {{W{1'b0}}, issue_i.op_b};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mul_v1_q   <= 1'b0;
      mulhu_v1_q <= 1'b0;
      mulhu_v2_q <= 1'b0;
    end else begin
      mul_v1_q   <= fire & (lat == 2'd1);
      mulhu_v1_q <= fire & (lat == 2'd2);
      mulhu_v2_q <= mulhu_v1_q;
    end
  end

  // Stage 2 takes the high word before a following MUL overwrites it
  always_ff @(posedge clk_i) begin
    if (fire && (lat == 2'd1 || lat == 2'd2)) prod_q <= prod;
    if (mulhu_v1_q) hi_q <= prod_q[2*W-1:W];
  end

  ////////////////////////////////////////////////////////////////////
  // Divider
  ////////////////////////////////////////////////////////////////////

  assign div_start = fire & (lat == 2'd3);
  assign div_done  = (state_q == DIV_BUSY) && (cnt_q == CW'(`APU_DIV_CYCLES));

  // First step runs on the issue operands in the accept cycle
  always_comb begin
    if (state_q == DIV_IDLE) begin
      rem_in = '0;
      quo_in = issue_i.op_a;
      dvs_in = issue_i.op_b;
    end else begin
      rem_in = rem_q;
      quo_in = quo_q;
      dvs_in = dvs_q;
    end
  end

  // Two restoring steps per cycle
  // Divisor zero always subtracts, giving all ones and the dividend
  always_comb begin
    rem_n = rem_in;
    quo_n = quo_in;
    for (int i = 0; i < 2; i++) begin
      rem_n = {rem_n[W-1:0], quo_n[W-1]};
      quo_n = {quo_n[W-2:0], 1'b0};
      if (rem_n >= {1'b0, dvs_in}) begin
        rem_n    = rem_n - {1'b0, dvs_in};
        quo_n[0] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (div_start) begin
            state_q <= DIV_BUSY;
            cnt_q   <= CW'(1);
          end
        end
        DIV_BUSY: begin
          if (div_done) state_q <= DIV_IDLE;
          else          cnt_q   <= cnt_q + CW'(1);
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (div_start || (state_q == DIV_BUSY && !div_done)) begin
      rem_q <= rem_n;
      quo_q <= quo_n;
      dvs_q <= dvs_in;
    end
    if (div_start) is_rem_q <= (issue_i.op == APU_REMU);
  end

  ////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////

  assign result_valid_o = same_v | mul_v1_q | mulhu_v2_q | div_done;

  always_comb begin
    if (same_v)          result_o = sum;
    else if (mul_v1_q)   result_o = prod_q[W-1:0];
    else if (mulhu_v2_q) result_o = hi_q;
    else if (div_done)   result_o = is_rem_q ? rem_q[W-1:0] : quo_q;
    else                 result_o = '0;
  end

  // Dispatcher stalls keep the result sources apart
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({same_v, mul_v1_q, mulhu_v2_q, div_done}))
    else $error("apu_unit: two results in the same cycle");

endmodule

/* source/apu_dispatcher.sv */
//////////////////////////////////////////////////////////////////////
// Issues core requests to the unit and tags returning results
// At most two operations unreturned, in the in-flight and waiting slot
// Results must come back in issue order, the stall rules ensure that
// Writebacks to register 0 are dropped here
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "apu_settings.svh"

module apu_dispatcher
  import apu_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Core request, held while stall_o is high
  input  logic                      req_valid_i,
  input  apu_req_t                  req_i,
  // Dependency check inputs
  input  apu_reg_t [`APU_NARGS-1:0] rs_addr_i,
  input  logic [`APU_NARGS-1:0]     rs_valid_i,
  input  apu_reg_t                  wr_addr_i,
  input  logic                      wr_valid_i,
  // Unit side
  output logic                      issue_req_o,
  output apu_issue_t                issue_o,
  input  logic                      issue_gnt_i,
  input  logic                      result_valid_i,
  input  apu_data_t                 result_i,
  // Register file side
  output logic                      wb_valid_o,
  output apu_rsp_t                  wb_o,
  // Status
  output logic                      stall_o,
  output logic                      active_o,
  output logic                      read_dep_o,
  output logic                      write_dep_o
);

  apu_reg_t addr_inflight_q, addr_waiting_q;
  apu_reg_t addr_inflight_d, addr_waiting_d;
  apu_reg_t wb_addr;
  logic     valid_inflight_q, valid_waiting_q;
  logic     valid_inflight_d, valid_waiting_d;
  logic     valid_req, req_accepted, active;
  logic     returned_req, returned_inflight, returned_waiting;
  logic     live_req, live_inflight, live_waiting;
  logic     stall_full, stall_type, stall_nack;
  apu_lat_t lat_q, req_lat;

  logic [`APU_NARGS-1:0] rd_hit_req, rd_hit_inflight, rd_hit_waiting;
  logic                  wr_hit_req, wr_hit_inflight, wr_hit_waiting;

  assign req_lat      = apu_latency(req_i.op);
  assign active       = valid_inflight_q | valid_waiting_q;

  // Request goes to the unit unless a full or type stall holds it
  assign valid_req    = req_valid_i & ~(stall_full | stall_type);
  assign req_accepted = valid_req & issue_gnt_i;

  ////////////////////////////////////////////////////////////////////
  // Result ownership
  ////////////////////////////////////////////////////////////////////

  // Oldest outstanding operation owns the result
  assign returned_req      = req_accepted & result_valid_i & ~valid_inflight_q
                             & ~valid_waiting_q;
  assign returned_inflight = valid_inflight_q & result_valid_i & ~valid_waiting_q;
  assign returned_waiting  = valid_waiting_q & result_valid_i;

  always_comb begin
    valid_inflight_d = valid_inflight_q;
    valid_waiting_d  = valid_waiting_q;
    addr_inflight_d  = addr_inflight_q;
    addr_waiting_d   = addr_waiting_q;
    if (req_accepted && !returned_req) begin
      // New multicycle operation becomes the in-flight one
      valid_inflight_d = 1'b1;
      addr_inflight_d  = req_i.rd;
      // Older in-flight one moves down if still unreturned
      if ((valid_inflight_q && !returned_inflight) || returned_waiting) begin
        valid_waiting_d = 1'b1;
        addr_waiting_d  = addr_inflight_q;
      end
    end else if (returned_inflight) begin
      valid_inflight_d = 1'b0;
    end else if (returned_waiting) begin
      valid_waiting_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_inflight_q <= 1'b0;
      valid_waiting_q  <= 1'b0;
      addr_inflight_q  <= '0;
      addr_waiting_q   <= '0;
      lat_q            <= '0;
    end else begin
      valid_inflight_q <= valid_inflight_d;
      valid_waiting_q  <= valid_waiting_d;
      addr_inflight_q  <= addr_inflight_d;
      addr_waiting_q   <= addr_waiting_d;
      // Class of the youngest issued operation
      if (req_accepted) begin
        lat_q <= req_lat;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Stalls
  ////////////////////////////////////////////////////////////////////

  assign stall_full = req_valid_i & valid_inflight_q & valid_waiting_q;
  // A new result must not land before or on top of an older one
  // Same cycle ops would also overtake a two cycle op
  assign stall_type = req_valid_i & active & ((req_lat == 2'd0) | (req_lat == 2'd1)
                      | (req_lat == 2'd3) | ((lat_q - req_lat) == 2'd1));
  assign stall_nack = valid_req & ~issue_gnt_i;
  assign stall_o    = stall_full | stall_type | stall_nack;

  ////////////////////////////////////////////////////////////////////
  // Dependencies
  ////////////////////////////////////////////////////////////////////

  // Register 0 never counts
  for (genvar i = 0; i < `APU_NARGS; i++) begin : g_rs
    assign rd_hit_req[i]      = rs_valid_i[i] & (|rs_addr_i[i])
                                & (rs_addr_i[i] == req_i.rd);
    assign rd_hit_inflight[i] = rs_valid_i[i] & (|rs_addr_i[i])
                                & (rs_addr_i[i] == addr_inflight_q);
    assign rd_hit_waiting[i]  = rs_valid_i[i] & (|rs_addr_i[i])
                                & (rs_addr_i[i] == addr_waiting_q);
  end

  assign wr_hit_req      = wr_valid_i & (|wr_addr_i) & (wr_addr_i == req_i.rd);
  assign wr_hit_inflight = wr_valid_i & (|wr_addr_i) & (wr_addr_i == addr_inflight_q);
  assign wr_hit_waiting  = wr_valid_i & (|wr_addr_i) & (wr_addr_i == addr_waiting_q);

  // Only destinations still unreturned after this cycle
  assign live_req      = valid_req & ~returned_req;
  assign live_inflight = valid_inflight_q & ~returned_inflight;
  assign live_waiting  = valid_waiting_q & ~returned_waiting;

  assign read_dep_o  = (|rd_hit_req & live_req) | (|rd_hit_inflight & live_inflight)
                       | (|rd_hit_waiting & live_waiting);
  assign write_dep_o = (wr_hit_req & live_req) | (wr_hit_inflight & live_inflight)
                       | (wr_hit_waiting & live_waiting);

  ////////////////////////////////////////////////////////////////////
  // Issue and writeback
  ////////////////////////////////////////////////////////////////////

  assign issue_req_o = valid_req;
  assign issue_o     = '{op: req_i.op, op_a: req_i.op_a, op_b: req_i.op_b};

  always_comb begin
    wb_addr = '0;
    if (returned_req)      wb_addr = req_i.rd;
    if (returned_inflight) wb_addr = addr_inflight_q;
    if (returned_waiting)  wb_addr = addr_waiting_q;
  end

  assign wb_valid_o = result_valid_i & (|wb_addr);
  assign wb_o       = '{result: result_i, rd: wb_addr};
  assign active_o   = active;

  // Unit must not return a result nobody waits for
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_i |-> (returned_req | valid_inflight_q | valid_waiting_q))
    else $warning("apu_dispatcher: result returned with nothing outstanding");

endmodule

/* source/apu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types of the accelerator dispatch subsystem
// Latency classes: 0 same cycle, 1 and 2 pipelined, 3 iterative
//////////////////////////////////////////////////////////////////////

`include "apu_settings.svh"

package apu_pkg;

  // Data word, register address and latency class
  typedef logic [`APU_DATA_W-1:0] apu_data_t;
  typedef logic [`APU_REG_AW-1:0] apu_reg_t;
  typedef logic [1:0]             apu_lat_t;

  typedef enum logic [2:0] {
    APU_ADD   = 3'd0,
    APU_SUB   = 3'd1,
    APU_MUL   = 3'd2,
    APU_MULHU = 3'd3,
    APU_DIVU  = 3'd4,
    APU_REMU  = 3'd5
  } apu_op_e;

  // Core side request, held while stalled
  typedef struct packed {
    apu_op_e   op;
    apu_data_t op_a;
    apu_data_t op_b;
    apu_reg_t  rd;
  } apu_req_t;

  // Dispatcher to unit
  typedef struct packed {
    apu_op_e   op;
    apu_data_t op_a;
    apu_data_t op_b;
  } apu_issue_t;

  // Dispatcher to register file
  typedef struct packed {
    apu_data_t result;
    apu_reg_t  rd;
  } apu_rsp_t;

  // Latency class of each operation
  function automatic apu_lat_t apu_latency(apu_op_e op);
    case (op)
      APU_ADD, APU_SUB: return 2'd0;
      APU_MUL:          return 2'd1;
      APU_MULHU:        return 2'd2;
      default:          return 2'd3;
    endcase
  endfunction

endpackage

/* include/apu_settings.svh */
//////////////////////////////////////////////////////////////////////
// Sizing macros for the accelerator dispatch subsystem
// APU_DATA_W must equal 2 * APU_DIV_CYCLES, two quotient bits a cycle
// APU_NARGS also sets the number of source register ports
//////////////////////////////////////////////////////////////////////

`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// Operand and result width
`define APU_DATA_W 32

// Register address width, 32 architectural registers
`define APU_REG_AW 5

// Operands per request, one source register each
`define APU_NARGS 2

// Divider iterations from accepted issue to result
`define APU_DIV_CYCLES 16

`endif
